// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef logic [5:0] funct_t;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,
        FWD_MEM  = 2'd1,
        FWD_WB   = 2'd2
    } fwd_sel_t;

    localparam int    IMEM_DEPTH = 256;
    localparam int    DMEM_DEPTH = 256;
    // loads read the input port, stores drive the output port
    localparam word_t IO_ADDR    = 32'h0000_FFFC;

    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } r_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target;
    } j_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        alu_op_t  alu_op;
        word_t    operand_a;
        word_t    operand_b;
        word_t    store_data;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t dest;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        word_t    result;
        reg_idx_t dest;
    } mem_wb_t;

    typedef struct packed {
        logic pc_stall;
        logic if_id_stall;
        logic if_id_flush;
        logic id_ex_bubble;
    } hazard_t;

endpackage

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       load_en,
    input  logic [7:0] load_addr,
    input  word_t      load_data,
    input  hazard_t    hazard,
    input  logic       redirect,
    input  word_t      target,
    output instr_t     if_instr,
    output word_t      if_pc,
    output logic       if_valid
);

    word_t imem [IMEM_DEPTH];
    word_t pc;
    word_t fetch_word;

    // program load only while the core is held
    always_ff @(posedge clk) begin
        if (load_en && !run)
            imem[load_addr] <= load_data;
    end

    assign fetch_word = imem[pc[$clog2(IMEM_DEPTH)+1:2]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= '0;
        else if (!run)
            pc <= '0;
        else if (redirect)
            pc <= target;
        else if (!hazard.pc_stall)
            pc <= pc + 32'd4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            if_valid <= 1'b0;
        else if (!run || hazard.if_id_flush)
            if_valid <= 1'b0;
        else if (!hazard.if_id_stall)
            if_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!hazard.if_id_stall) begin
            if_instr <= fetch_word;
            if_pc    <= pc;
        end
    end

    a_no_load_while_run: assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> !run)
        else $error("instruction memory written while core runs");

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  instr_t   if_instr,
    input  word_t    if_pc,
    input  logic     if_valid,
    input  hazard_t  hazard,
    input  mem_wb_t  wb,
    output id_ex_t   id_ex,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    output logic     uses_rs,
    output logic     uses_rt,
    output logic     is_branch,
    output logic     redirect,
    output word_t    target
);

    word_t    regs [32];
    word_t    rs_val, rt_val, imm_ext, pc_plus4;
    logic     writes, mem_read, mem_write, use_imm, is_jump, taken;
    alu_op_t  alu_op;
    reg_idx_t dest;
    id_ex_t   id_next;

    assign rs_idx = if_instr.r.rs;
    assign rt_idx = if_instr.r.rt;

    always_comb begin
        writes    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_imm   = 1'b0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        alu_op    = ALU_ADD;
        dest      = if_instr.i.rt;
        if (if_valid) begin
            case (if_instr.r.opcode)
                OP_RTYPE: begin
                    writes  = 1'b1;
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                    dest    = if_instr.r.rd;
                    case (if_instr.r.funct)
                        FN_ADD:  alu_op = ALU_ADD;
                        FN_SUB:  alu_op = ALU_SUB;
                        FN_AND:  alu_op = ALU_AND;
                        FN_OR:   alu_op = ALU_OR;
                        FN_SLT:  alu_op = ALU_SLT;
                        default: writes = 1'b0;
                    endcase
                end
                OP_ADDI: {writes, uses_rs, use_imm} = 3'b111;
                OP_LW:   {writes, mem_read, uses_rs, use_imm} = 4'b1111;
                OP_SW:   {mem_write, uses_rs, uses_rt, use_imm} = 4'b1111;
                OP_BEQ, OP_BNE: {is_branch, uses_rs, uses_rt} = 3'b111;
                OP_J:    is_jump = 1'b1;
                default: ;
            endcase
        end
    end

    // write-back lands this cycle, so pass it straight through
    always_comb begin
        rs_val = (rs_idx == '0) ? '0 : regs[rs_idx];
        rt_val = (rt_idx == '0) ? '0 : regs[rt_idx];
        if (wb.valid && wb.reg_write && wb.dest == rs_idx && rs_idx != '0)
            rs_val = wb.result;
        if (wb.valid && wb.reg_write && wb.dest == rt_idx && rt_idx != '0)
            rt_val = wb.result;
    end

    always_ff @(posedge clk) begin
        if (wb.valid && wb.reg_write)
            regs[wb.dest] <= wb.result;
    end

    assign imm_ext  = {{16{if_instr.i.imm[15]}}, if_instr.i.imm};
    assign pc_plus4 = if_pc + 32'd4;
    assign taken    = is_branch && ((rs_val == rt_val) == (if_instr.i.opcode == OP_BEQ));
    assign target   = is_jump ? {pc_plus4[31:28], if_instr.j.target, 2'b00}
                              : pc_plus4 + {imm_ext[29:0], 2'b00};
    assign redirect = (taken || is_jump) && !hazard.id_ex_bubble;

    always_comb begin
        id_next.valid      = if_valid;
        // dest 0 never marked as written
        id_next.reg_write  = writes && dest != '0;
        id_next.mem_read   = mem_read;
        id_next.mem_write  = mem_write;
        id_next.alu_op     = alu_op;
        id_next.operand_a  = rs_val;
        id_next.operand_b  = use_imm ? imm_ext : rt_val;
        id_next.store_data = rt_val;
        id_next.rs         = uses_rs ? rs_idx : '0;
        id_next.rt         = uses_rt ? rt_idx : '0;
        id_next.dest       = dest;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ex <= '0;
        else if (hazard.id_ex_bubble)
            id_ex.valid <= 1'b0;
        else
            id_ex <= id_next;
    end

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb.valid && wb.reg_write && wb.dest == '0))
        else $error("write-back targets register 0");

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    output ex_mem_t  ex_mem,
    input  mem_wb_t  wb
);

    word_t a_val, b_fwd, b_val, alu_res;

    function automatic word_t pick(fwd_sel_t sel, word_t base, word_t mem_val, word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return base;
        endcase
    endfunction

    assign a_val = pick(fwd_a, id_ex.operand_a, ex_mem.alu_result, wb.result);
    assign b_fwd = pick(fwd_b, id_ex.store_data, ex_mem.alu_result, wb.result);
    // sw keeps its offset on b, rt only feeds the store data
    assign b_val = (id_ex.mem_write || fwd_b == FWD_NONE) ? id_ex.operand_b : b_fwd;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB: alu_res = a_val - b_val;
            ALU_AND: alu_res = a_val & b_val;
            ALU_OR:  alu_res = a_val | b_val;
            ALU_SLT: alu_res = {31'b0, $signed(a_val) < $signed(b_val)};
            default: alu_res = a_val + b_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.alu_result <= alu_res;
            ex_mem.store_data <= b_fwd;
            ex_mem.dest       <= id_ex.dest;
        end
    end

endmodule

// ==== verilog/memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ex_mem_t ex_mem,
    input  word_t   in_data,
    output mem_wb_t mem_wb,
    output logic    out_valid,
    output word_t   out_data
);

    word_t dmem [DMEM_DEPTH];
    logic  is_io;
    logic  store;
    word_t load_data;

    assign is_io     = ex_mem.alu_result == IO_ADDR;
    assign store     = ex_mem.valid && ex_mem.mem_write;
    assign load_data = is_io ? in_data : dmem[ex_mem.alu_result[$clog2(DMEM_DEPTH)+1:2]];

    always_ff @(posedge clk) begin
        if (store && !is_io)
            dmem[ex_mem.alu_result[$clog2(DMEM_DEPTH)+1:2]] <= ex_mem.store_data;
    end

    // output port, one pulse per store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else
            out_valid <= store && is_io;
    end

    always_ff @(posedge clk) begin
        if (store && is_io)
            out_data <= ex_mem.store_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.result    <= ex_mem.mem_read ? load_data : ex_mem.alu_result;
            mem_wb.dest      <= ex_mem.dest;
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write) |-> ex_mem.alu_result[1:0] == 2'b00)
        else $error("unaligned data access at %h", ex_mem.alu_result);

endmodule

// ==== verilog/pipeline_control.sv ====
`timescale 1ns/1ns

module pipeline_control import cpu_pkg::*; (
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     uses_rs,
    input  logic     uses_rt,
    input  logic     is_branch,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    input  logic     redirect,
    output hazard_t  hazard,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    logic ex_hit, mem_hit;
    logic load_use, branch_wait, stall;

    // does a pending write collide with a source read in decode
    function automatic logic src_hit(logic vld, logic wr, reg_idx_t dest,
                                     logic use_a, reg_idx_t a,
                                     logic use_b, reg_idx_t b);
        logic live;
        live = vld && wr && dest != '0;
        return live && ((use_a && a == dest) || (use_b && b == dest));
    endfunction

    function automatic fwd_sel_t fwd_src(reg_idx_t src, ex_mem_t m, mem_wb_t w);
        if (src == '0)
            return FWD_NONE;
        if (m.valid && m.reg_write && m.dest == src)
            return FWD_MEM;
        if (w.valid && w.reg_write && w.dest == src)
            return FWD_WB;
        return FWD_NONE;
    endfunction

    assign ex_hit  = src_hit(id_ex.valid, id_ex.reg_write, id_ex.dest,
                             uses_rs, rs_idx, uses_rt, rt_idx);
    assign mem_hit = src_hit(ex_mem.valid, ex_mem.reg_write, ex_mem.dest,
                             uses_rs, rs_idx, uses_rt, rt_idx);

    assign load_use = ex_hit && id_ex.mem_read;
    // branches compare in decode, so wait until both stages are clear
    assign branch_wait = is_branch && (ex_hit || mem_hit);
    assign stall = load_use || branch_wait;

    always_comb begin
        hazard.pc_stall     = stall;
        hazard.if_id_stall  = stall;
        hazard.id_ex_bubble = stall;
        hazard.if_id_flush  = redirect;
    end

    assign fwd_a = fwd_src(id_ex.rs, ex_mem, mem_wb);
    assign fwd_b = fwd_src(id_ex.rt, ex_mem, mem_wb);

    // decode must hold back its redirect while a stall is raised
    always_comb begin
        a_stall_flush_excl: assert (!(hazard.if_id_stall && hazard.if_id_flush))
            else $error("IF/ID stall and flush raised together");
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    input  logic       load_en,
    input  logic [7:0] load_addr,
    input  word_t      load_data,
    input  word_t      in_data,
    output logic       out_valid,
    output word_t      out_data
);

    // if stage
    instr_t   if_instr;
    word_t    if_pc;
    logic     if_valid;

    // id stage
    id_ex_t   id_ex;
    reg_idx_t id_rs_idx, id_rt_idx;
    logic     id_uses_rs, id_uses_rt, id_is_branch;
    logic     id_redirect;
    word_t    id_target;

    // ex, mem stages
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;

    // control
    hazard_t  hazard;
    fwd_sel_t fwd_a, fwd_b;

    fetch_stage fetch_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .hazard     (hazard),
        .redirect   (id_redirect),
        .target     (id_target),
        .if_instr   (if_instr),
        .if_pc      (if_pc),
        .if_valid   (if_valid)
    );

    decode_stage decode_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .if_instr   (if_instr),
        .if_pc      (if_pc),
        .if_valid   (if_valid),
        .hazard     (hazard),
        .wb         (mem_wb),
        .id_ex      (id_ex),
        .rs_idx     (id_rs_idx),
        .rt_idx     (id_rt_idx),
        .uses_rs    (id_uses_rs),
        .uses_rt    (id_uses_rt),
        .is_branch  (id_is_branch),
        .redirect   (id_redirect),
        .target     (id_target)
    );

    execute_stage execute_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_ex      (id_ex),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .ex_mem     (ex_mem),
        .wb         (mem_wb)
    );

    memory_stage memory_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .in_data    (in_data),
        .mem_wb     (mem_wb),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

    pipeline_control pipeline_control (
        .rs_idx     (id_rs_idx),
        .rt_idx     (id_rt_idx),
        .uses_rs    (id_uses_rs),
        .uses_rt    (id_uses_rt),
        .is_branch  (id_is_branch),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .redirect   (id_redirect),
        .hazard     (hazard),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

endmodule

// ==== testbench/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu import cpu_pkg::*; ();

    localparam int         RUN_LIMIT = 400;
    // r7 + 0x7ffe lands on the i/o word
    localparam int         IO_BASE   = 7;
    localparam logic [15:0] IO_OFS   = 16'h7FFE;
    localparam word_t      POISON    = 32'h0000_0BAD;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       load_en;
    logic [7:0] load_addr;
    word_t      load_data;
    word_t      in_data;
    logic       out_valid;
    word_t      out_data;

    int         seed = 32'h5bec;
    word_t      exp_fifo [64];
    logic [5:0] wr_idx = '0;
    logic [5:0] rd_idx = '0;
    word_t      prog [64];
    logic [5:0] prog_len = '0;
    string      test_name = "reset";
    int         mismatches = 0;
    int         protocol_errors = 0;
    int         timeouts = 0;
    logic       timed_out = 1'b0;

    cpu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (run),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // head moves on once the pulse has been seen
    always @(posedge clk) begin
        if (out_valid && rd_idx != wr_idx)
            rd_idx <= rd_idx + 6'd1;
    end

    // outputs settle by the falling edge
    a_out_value: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid && rd_idx != wr_idx |-> out_data == exp_fifo[rd_idx])
        else begin
            mismatches++;
            $display("Fail %s: expected %h, actual %h", test_name, exp_fifo[rd_idx], out_data);
        end

    a_no_stray: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid |-> rd_idx != wr_idx)
        else begin
            protocol_errors++;
            $display("%s: out_valid rose with no value expected (data %h)", test_name, out_data);
        end

    a_hold_quiet: assert property (@(negedge clk)
        !(rst_n && run) |-> !out_valid)
        else begin
            protocol_errors++;
            $display("%s: out_valid high during reset or while the core is held", test_name);
        end

    a_no_poison: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid |-> out_data != POISON)
        else begin
            protocol_errors++;
            $display("%s: a skipped store reached the output port", test_name);
        end

    function automatic word_t sext16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic logic [15:0] rand16();
        word_t r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic word_t rtype(funct_t fn, int rd, int rs, int rt);
        return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic word_t itype(opcode_t op, int rt, int rs, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    // offset counts words from the next instruction
    function automatic word_t branch(opcode_t op, int rs, int rt, int from, int to);
        int ofs;
        ofs = to - from - 1;
        return {op, rs[4:0], rt[4:0], ofs[15:0]};
    endfunction

    function automatic word_t jump_to(int index);
        return {OP_J, index[25:0]};
    endfunction

    function automatic void start_program(string name);
        test_name = name;
        prog_len = '0;
    endfunction

    function automatic void emit(word_t w);
        prog[prog_len] = w;
        prog_len = prog_len + 6'd1;
    endfunction

    function automatic void store_out(int rt);
        emit(itype(OP_SW, rt, IO_BASE, IO_OFS));
    endfunction

    // spin in place so nothing past the end runs
    function automatic void halt();
        emit(jump_to(int'(prog_len)));
    endfunction

    function automatic void expect_value(word_t v);
        exp_fifo[wr_idx] = v;
        wr_idx = wr_idx + 6'd1;
    endfunction

    task automatic drive_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic load_program();
        logic [5:0] idx;
        idx = '0;
        while (idx != prog_len) begin
            drive_slot();
            load_en   = 1'b1;
            load_addr = {2'b00, idx};
            load_data = prog[idx];
            idx = idx + 6'd1;
        end
        drive_slot();
        load_en = 1'b0;
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        drive_slot();
        run = 1'b1;
        while (rd_idx != wr_idx && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (rd_idx != wr_idx) begin
            $display("%s: timed out waiting for out_valid, %0d values never arrived",
                     test_name, wr_idx - rd_idx);
            timeouts++;
            timed_out = 1'b1;
        end
        // quiet stretch to catch late strays
        repeat (8) @(posedge clk);
        drive_slot();
        run = 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic check_alu();
        logic [15:0] a, b;
        word_t sa, sb;
        a  = rand16();
        b  = rand16();
        sa = sext16(a);
        sb = sext16(b);
        start_program("alu");
        emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
        emit(itype(OP_ADDI, 1, 0, a));
        emit(itype(OP_ADDI, 2, 0, b));
        emit(rtype(FN_ADD, 3, 1, 2));
        store_out(3);
        emit(rtype(FN_SUB, 4, 1, 2));
        store_out(4);
        emit(rtype(FN_AND, 5, 1, 2));
        store_out(5);
        emit(rtype(FN_OR, 6, 1, 2));
        store_out(6);
        emit(rtype(FN_SLT, 8, 1, 2));
        store_out(8);
        halt();
        expect_value(sa + sb);
        expect_value(sa - sb);
        expect_value(sa & sb);
        expect_value(sa | sb);
        expect_value(($signed(sa) < $signed(sb)) ? 32'd1 : 32'd0);
        load_program();
        run_program();
    endtask

    task automatic check_load_use();
        logic [15:0] v;
        v = rand16();
        start_program("load_use");
        emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
        emit(itype(OP_ADDI, 1, 0, v));
        emit(itype(OP_SW, 1, 0, 16'h0040));
        emit(itype(OP_LW, 2, 0, 16'h0040));
        emit(itype(OP_ADDI, 3, 2, 16'h0001));
        store_out(3);
        // loaded word used straight away as store data
        emit(itype(OP_LW, 4, 0, 16'h0040));
        store_out(4);
        halt();
        expect_value(sext16(v) + 32'd1);
        expect_value(sext16(v));
        load_program();
        run_program();
    endtask

    task automatic check_branches();
        word_t sum;
        sum = '0;
        for (int k = 5; k > 0; k--)
            sum = sum + word_t'(k);
        start_program("branch");
        emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
        emit(itype(OP_ADDI, 1, 0, 16'd5));
        emit(itype(OP_ADDI, 2, 0, 16'd0));
        emit(rtype(FN_ADD, 2, 2, 1));
        emit(itype(OP_ADDI, 1, 1, 16'hFFFF));
        emit(branch(OP_BNE, 1, 0, 5, 3));
        store_out(2);
        emit(itype(OP_ADDI, 3, 0, POISON[15:0]));
        emit(itype(OP_ADDI, 4, 0, 16'h600D));
        // not taken, 0 against the sum
        emit(branch(OP_BEQ, 1, 2, 9, 11));
        emit(jump_to(12));
        store_out(3);
        emit(branch(OP_BEQ, 1, 0, 12, 14));
        store_out(3);
        store_out(4);
        halt();
        expect_value(sum);
        expect_value(32'h0000_600D);
        load_program();
        run_program();
    endtask

    task automatic check_input();
        logic [15:0] c;
        c = rand16();
        start_program("input");
        emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
        emit(itype(OP_LW, 1, IO_BASE, IO_OFS));
        emit(itype(OP_ADDI, 2, 1, c));
        store_out(2);
        halt();
        drive_slot();
        in_data = $random(seed);
        expect_value(in_data + sext16(c));
        load_program();
        run_program();
    endtask

    task automatic check_reload();
        start_program("reload_old");
        emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
        emit(itype(OP_ADDI, 1, 0, 16'h1A1A));
        store_out(1);
        emit(itype(OP_ADDI, 2, 0, 16'h2A2A));
        store_out(2);
        halt();
        expect_value(32'h0000_1A1A);
        expect_value(32'h0000_2A2A);
        load_program();
        run_program();
        if (!timed_out) begin
            // held a while, then reset with the old code still in memory
            repeat (20) @(posedge clk);
            drive_slot();
            rst_n = 1'b0;
            repeat (4) @(posedge clk);
            drive_slot();
            rst_n = 1'b1;
            start_program("reload_new");
            emit(itype(OP_ADDI, IO_BASE, 0, IO_OFS));
            emit(itype(OP_ADDI, 5, 0, 16'h3B3B));
            store_out(5);
            halt();
            expect_value(32'h0000_3B3B);
            load_program();
            run_program();
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        in_data   = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_alu();
        if (!timed_out)
            check_load_use();
        if (!timed_out)
            check_branches();
        if (!timed_out)
            check_input();
        if (!timed_out)
            check_reload();
        $display("errors: %0d value mismatches, %0d protocol errors, %0d timeouts",
                 mismatches, protocol_errors, timeouts);
        if (mismatches == 0 && protocol_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/pipeline_control.sv
verilog/cpu_top.sv
testbench/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
